// File: logic/dc_fifo_consts.svh
/*
 * Dual-clock streaming FIFO constants
 * Data and pointer widths, memory depth, synchronizer depth and the
 * CSR field layout shared by the RTL and the testbench
 */
`ifndef DC_FIFO_CONSTS_SVH
`define DC_FIFO_CONSTS_SVH

`define DCF_DATA_WIDTH      8
`define DCF_ADDR_WIDTH      4
`define DCF_DEPTH           16
`define DCF_SYNC_STAGES     2

// Fill level and threshold share the low CSR field
`define DCF_CSR_LEVEL_BITS  24
`define DCF_CSR_ADDR_LEVEL  1'b0
`define DCF_CSR_ADDR_THRESH 1'b1
`define DCF_CSR_WIDTH       32

`endif

// File: logic/dc_fifo_pkg.sv
/*
 * Dual-clock streaming FIFO types
 * Pointer, address, level, payload and threshold types, plus the
 * Gray code conversions used on both sides of the clock crossing
 */
`include "dc_fifo_consts.svh"

package dc_fifo_pkg;

    // Pointers carry one extra bit to tell full from empty
    typedef logic [`DCF_ADDR_WIDTH:0]   ptr_t;
    typedef logic [`DCF_ADDR_WIDTH-1:0] addr_t;

    // Holds 0 to 17 with the output stage counted
    typedef logic [`DCF_ADDR_WIDTH:0] level_t;

    // Layout is {sop, eop, data}
    typedef logic [`DCF_DATA_WIDTH+1:0] payload_t;

    typedef logic [`DCF_CSR_LEVEL_BITS-1:0] thresh_t;

    // ------------------------------
    // Gray conversion
    // ------------------------------
    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[$bits(ptr_t)-1] = gray[$bits(ptr_t)-1];
        // Each binary bit folds in all Gray bits above it
        for (int i = $bits(ptr_t) - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

// File: logic/dc_fifo_mem.sv
/*
 * Dual-clock FIFO storage
 * Simple dual-port memory, written on the input clock and read into
 * a register on the output clock
 */
`timescale 1ns/1ps
`include "dc_fifo_consts.svh"

module dc_fifo_mem (
    input  logic                  in_clk,
    input  logic                  wr_en,
    input  dc_fifo_pkg::addr_t    wr_addr,
    input  dc_fifo_pkg::payload_t wr_payload,
    input  logic                  out_clk,
    input  dc_fifo_pkg::addr_t    rd_addr,
    output dc_fifo_pkg::payload_t rd_payload
);
    import dc_fifo_pkg::*;

    payload_t mem [`DCF_DEPTH];

    always_ff @(posedge in_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_payload;
        end
    end

    // Read address is the next read pointer, so the head is ready a cycle later
    always_ff @(posedge out_clk) begin
        rd_payload <= mem[rd_addr];
    end

endmodule

// File: logic/dc_fifo_ptr_sync.sv
/*
 * Gray pointer synchronizer
 * Carries a Gray-coded pointer into the destination clock domain
 * through a chain of flip-flops, then returns it in binary
 */
`timescale 1ns/1ps
`include "dc_fifo_consts.svh"

module dc_fifo_ptr_sync #(
    parameter int STAGES = `DCF_SYNC_STAGES
) (
    input  logic              in_clk,
    input  logic              in_reset_n,
    input  dc_fifo_pkg::ptr_t gray_in,
    output dc_fifo_pkg::ptr_t bin_out
);
    import dc_fifo_pkg::*;

    ptr_t sync_q [STAGES];

    // Only one bit of gray_in moves per source update
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            for (int i = 0; i < STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= gray_in;
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign bin_out = gray2bin(sync_q[STAGES-1]);

endmodule

// File: logic/dc_fifo_wr_ctrl.sv
/*
 * FIFO write side control
 * Write pointer and its Gray copy, full flag and in_ready, and the
 * input fill level seen from the write clock domain
 */
`timescale 1ns/1ps

module dc_fifo_wr_ctrl (
    input  logic                in_clk,
    input  logic                in_reset_n,
    input  logic                in_valid,
    output logic                in_ready,
    output logic                wr_en,
    output dc_fifo_pkg::addr_t  wr_addr,
    output dc_fifo_pkg::ptr_t   wr_gray,
    input  dc_fifo_pkg::ptr_t   rd_ptr_sync,
    output dc_fifo_pkg::level_t in_level
);
    import dc_fifo_pkg::*;

    ptr_t wr_ptr;
    ptr_t next_wr_ptr;
    logic full;

    // ------------------------------
    // Write pointer
    // ------------------------------
    assign wr_en       = in_valid && in_ready;
    assign wr_addr     = wr_ptr[$bits(addr_t)-1:0];
    assign next_wr_ptr = wr_en ? wr_ptr + 1'b1 : wr_ptr;

    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            wr_ptr <= '0;
        end else begin
            wr_ptr <= next_wr_ptr;
        end
    end

    // Full when addresses match and the wrap bits differ
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            full <= 1'b0;
        end else begin
            full <= (next_wr_ptr[$bits(addr_t)-1:0] == rd_ptr_sync[$bits(addr_t)-1:0]) &&
                    (next_wr_ptr[$bits(addr_t)] != rd_ptr_sync[$bits(addr_t)]);
        end
    end

    assign in_ready = !full;

    // ------------------------------
    // Crossing register and level
    // ------------------------------
    // Gray copy follows the write, so the memory word is stable before it crosses
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            wr_gray <= '0;
        end else begin
            wr_gray <= bin2gray(wr_ptr);
        end
    end

    // Excludes the output stage on the far side
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            in_level <= '0;
        end else begin
            in_level <= level_t'(next_wr_ptr - rd_ptr_sync);
        end
    end

endmodule

// File: logic/dc_fifo_rd_ctrl.sv
/*
 * FIFO read side control
 * Read pointer and its Gray copy, empty flag, the registered output
 * stage and the output fill level including that stage
 */
`timescale 1ns/1ps
`include "dc_fifo_consts.svh"

module dc_fifo_rd_ctrl (
    input  logic                        out_clk,
    input  logic                        out_reset_n,
    input  dc_fifo_pkg::ptr_t           wr_ptr_sync,
    output dc_fifo_pkg::addr_t          rd_addr,
    output dc_fifo_pkg::ptr_t           rd_gray,
    input  dc_fifo_pkg::payload_t       rd_payload,
    output logic [`DCF_DATA_WIDTH-1:0]  out_data,
    output logic                        out_startofpacket,
    output logic                        out_endofpacket,
    output logic                        out_valid,
    input  logic                        out_ready,
    output dc_fifo_pkg::level_t         out_level
);
    import dc_fifo_pkg::*;

    ptr_t     rd_ptr;
    ptr_t     next_rd_ptr;
    ptr_t     fifo_level;
    logic     empty;
    logic     stage_load;
    logic     take;
    payload_t out_payload;

    // ------------------------------
    // Read pointer and empty
    // ------------------------------
    // Stage loads when it is free or being drained this cycle
    assign stage_load  = out_ready || !out_valid;
    assign take        = stage_load && !empty;
    assign next_rd_ptr = take ? rd_ptr + 1'b1 : rd_ptr;
    assign rd_addr     = next_rd_ptr[$bits(addr_t)-1:0];

    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            rd_ptr  <= '0;
            empty   <= 1'b1;
            rd_gray <= '0;
        end else begin
            rd_ptr  <= next_rd_ptr;
            empty   <= (next_rd_ptr == wr_ptr_sync);
            rd_gray <= bin2gray(rd_ptr);
        end
    end

    // ------------------------------
    // Output stage
    // ------------------------------
    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            out_valid <= 1'b0;
        end else if (stage_load) begin
            out_valid <= !empty;
        end
    end

    always_ff @(posedge out_clk) begin
        if (stage_load) begin
            out_payload <= rd_payload;
        end
    end

    assign out_startofpacket = out_payload[`DCF_DATA_WIDTH+1];
    assign out_endofpacket   = out_payload[`DCF_DATA_WIDTH];
    assign out_data          = out_payload[`DCF_DATA_WIDTH-1:0];

    // ------------------------------
    // Output fill level
    // ------------------------------
    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            fifo_level <= '0;
        end else begin
            fifo_level <= wr_ptr_sync - next_rd_ptr;
        end
    end

    // A full memory plus a loaded stage reads 17
    assign out_level = level_t'(fifo_level) + level_t'(out_valid);

endmodule

// File: logic/dc_fifo_level_csr.sv
/*
 * Fill level CSR and threshold status
 * Two-register CSR for one side of the FIFO: fill level at address 0,
 * threshold at address 1, plus the streamed status bit that compares
 * the level against the threshold
 */
`timescale 1ns/1ps
`include "dc_fifo_consts.svh"

module dc_fifo_level_csr #(
    parameter bit STATUS_BELOW = 1'b0
) (
    input  logic                       in_clk,
    input  logic                       in_reset_n,
    input  dc_fifo_pkg::level_t        level,
    input  logic                       csr_address,
    input  logic                       csr_read,
    input  logic                       csr_write,
    input  logic [`DCF_CSR_WIDTH-1:0]  csr_writedata,
    output logic [`DCF_CSR_WIDTH-1:0]  csr_readdata,
    output logic                       status_valid,
    output logic                       status_data
);
    import dc_fifo_pkg::*;

    localparam int PAD_BITS = `DCF_CSR_WIDTH - `DCF_CSR_LEVEL_BITS;

    thresh_t thresh;
    thresh_t level_ext;
    logic    status_next;

    assign level_ext = thresh_t'(level);

    // ------------------------------
    // CSR access
    // ------------------------------
    // Write wins over a read in the same cycle
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            thresh       <= '0;
            csr_readdata <= '0;
        end else if (csr_write) begin
            if (csr_address == `DCF_CSR_ADDR_THRESH) begin
                thresh <= csr_writedata[`DCF_CSR_LEVEL_BITS-1:0];
            end
        end else if (csr_read) begin
            if (csr_address == `DCF_CSR_ADDR_LEVEL) begin
                csr_readdata <= {{PAD_BITS{1'b0}}, level_ext};
            end else begin
                csr_readdata <= {{PAD_BITS{1'b0}}, thresh};
            end
        end
    end

    // ------------------------------
    // Streamed status
    // ------------------------------
    // Almost-empty looks below, almost-full looks above
    assign status_next = STATUS_BELOW ? (level_ext <= thresh) : (level_ext >= thresh);

    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            status_valid <= 1'b0;
            status_data  <= 1'b0;
        end else begin
            status_valid <= 1'b1;
            status_data  <= status_next;
        end
    end

endmodule

// File: logic/dc_fifo_top.sv
/*
 * Dual-clock streaming FIFO
 * 16-entry FIFO for 8-bit words with packet flags, written on in_clk
 * and read on out_clk, with Gray pointer crossing, a registered output
 * stage, and a fill level CSR and status bit on each side
 */
`timescale 1ns/1ps
`include "dc_fifo_consts.svh"

module dc_fifo_top (
    input  logic                       in_clk,
    input  logic                       in_reset_n,
    input  logic                       out_clk,
    input  logic                       out_reset_n,

    // Input stream
    input  logic [`DCF_DATA_WIDTH-1:0] in_data,
    input  logic                       in_startofpacket,
    input  logic                       in_endofpacket,
    input  logic                       in_valid,
    output logic                       in_ready,

    // Output stream
    output logic [`DCF_DATA_WIDTH-1:0] out_data,
    output logic                       out_startofpacket,
    output logic                       out_endofpacket,
    output logic                       out_valid,
    input  logic                       out_ready,

    // Input side CSR
    input  logic                       in_csr_address,
    input  logic                       in_csr_read,
    input  logic                       in_csr_write,
    input  logic [`DCF_CSR_WIDTH-1:0]  in_csr_writedata,
    output logic [`DCF_CSR_WIDTH-1:0]  in_csr_readdata,

    // Output side CSR
    input  logic                       out_csr_address,
    input  logic                       out_csr_read,
    input  logic                       out_csr_write,
    input  logic [`DCF_CSR_WIDTH-1:0]  out_csr_writedata,
    output logic [`DCF_CSR_WIDTH-1:0]  out_csr_readdata,

    // Status
    output logic                       almost_full_valid,
    output logic                       almost_full_data,
    output logic                       almost_empty_valid,
    output logic                       almost_empty_data
);
    import dc_fifo_pkg::*;

    logic     wr_en;
    addr_t    wr_addr;
    addr_t    rd_addr;
    payload_t wr_payload;
    payload_t rd_payload;
    ptr_t     wr_gray;
    ptr_t     rd_gray;
    ptr_t     wr_ptr_sync;
    ptr_t     rd_ptr_sync;
    level_t   in_level;
    level_t   out_level;

    assign wr_payload = {in_startofpacket, in_endofpacket, in_data};

    // ------------------------------
    // Write domain
    // ------------------------------
    dc_fifo_wr_ctrl i_wr_ctrl (
        .in_clk      (in_clk),
        .in_reset_n  (in_reset_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_gray     (wr_gray),
        .rd_ptr_sync (rd_ptr_sync),
        .in_level    (in_level)
    );

    dc_fifo_ptr_sync #(.STAGES(`DCF_SYNC_STAGES)) i_rd_ptr_sync (
        .in_clk     (in_clk),
        .in_reset_n (in_reset_n),
        .gray_in    (rd_gray),
        .bin_out    (rd_ptr_sync)
    );

    dc_fifo_level_csr #(.STATUS_BELOW(1'b0)) i_in_csr (
        .in_clk        (in_clk),
        .in_reset_n    (in_reset_n),
        .level         (in_level),
        .csr_address   (in_csr_address),
        .csr_read      (in_csr_read),
        .csr_write     (in_csr_write),
        .csr_writedata (in_csr_writedata),
        .csr_readdata  (in_csr_readdata),
        .status_valid  (almost_full_valid),
        .status_data   (almost_full_data)
    );

    dc_fifo_mem i_mem (
        .in_clk     (in_clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_payload (wr_payload),
        .out_clk    (out_clk),
        .rd_addr    (rd_addr),
        .rd_payload (rd_payload)
    );

    // ------------------------------
    // Read domain
    // ------------------------------
    dc_fifo_ptr_sync #(.STAGES(`DCF_SYNC_STAGES)) i_wr_ptr_sync (
        .in_clk     (out_clk),
        .in_reset_n (out_reset_n),
        .gray_in    (wr_gray),
        .bin_out    (wr_ptr_sync)
    );

    dc_fifo_rd_ctrl i_rd_ctrl (
        .out_clk           (out_clk),
        .out_reset_n       (out_reset_n),
        .wr_ptr_sync       (wr_ptr_sync),
        .rd_addr           (rd_addr),
        .rd_gray           (rd_gray),
        .rd_payload        (rd_payload),
        .out_data          (out_data),
        .out_startofpacket (out_startofpacket),
        .out_endofpacket   (out_endofpacket),
        .out_valid         (out_valid),
        .out_ready         (out_ready),
        .out_level         (out_level)
    );

    dc_fifo_level_csr #(.STATUS_BELOW(1'b1)) i_out_csr (
        .in_clk        (out_clk),
        .in_reset_n    (out_reset_n),
        .level         (out_level),
        .csr_address   (out_csr_address),
        .csr_read      (out_csr_read),
        .csr_write     (out_csr_write),
        .csr_writedata (out_csr_writedata),
        .csr_readdata  (out_csr_readdata),
        .status_valid  (almost_empty_valid),
        .status_data   (almost_empty_data)
    );

endmodule

// File: sim/tb_clk_gen.sv
/*
 * Testbench clock and reset source
 * Free-running clock and an active-low reset held for a few cycles
 */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

    initial begin
        // A real falling edge before the first clock starts the async reset
        reset_n = 1'b1;
        #(PERIOD_NS / 4.0);
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

// File: sim/dc_fifo_monitor.sv
/*
 * Dual-clock FIFO stream monitor
 * Reference queue of accepted beats, compared in order against the
 * beats that leave the FIFO, plus the value comparisons and counters
 */
`timescale 1ns/1ps
`include "dc_fifo_consts.svh"

module dc_fifo_monitor (
    input logic                       in_clk,
    input logic [`DCF_DATA_WIDTH-1:0] in_data,
    input logic                       in_startofpacket,
    input logic                       in_endofpacket,
    input logic                       in_valid,
    input logic                       in_ready,
    input logic                       out_clk,
    input logic [`DCF_DATA_WIDTH-1:0] out_data,
    input logic                       out_startofpacket,
    input logic                       out_endofpacket,
    input logic                       out_valid,
    input logic                       out_ready
);
    import dc_fifo_pkg::*;

    payload_t model_q [$];
    int       popped      = 0;
    int       stream_errs = 0;
    int       value_errs  = 0;

    function automatic int pending();
        return model_q.size();
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            value_errs++;
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // ------------------------------
    // Reference queue
    // ------------------------------
    always @(posedge in_clk) begin
        if (in_valid && in_ready) begin
            model_q.push_back({in_startofpacket, in_endofpacket, in_data});
        end
    end

    // Each beat taken must be the oldest one accepted
    always @(posedge out_clk) begin
        payload_t head;
        if (out_valid && out_ready) begin
            popped++;
            if (model_q.size() == 0) begin
                stream_errs++;
                $display("output beat %0d arrived while no accepted beat was pending", popped);
            end else begin
                head = model_q.pop_front();
                if (head !== {out_startofpacket, out_endofpacket, out_data}) begin
                    stream_errs++;
                    $display("error stream beat %0d: expected %h, actual %h", popped, head,
                             {out_startofpacket, out_endofpacket, out_data});
                end
            end
        end
    end

endmodule

// File: sim/dc_fifo_chk.sv
/*
 * Dual-clock FIFO assertions
 * Output hold under back-pressure, reset values and the level bound
 */
`timescale 1ns/1ps
`include "dc_fifo_consts.svh"

module dc_fifo_chk (
    input logic                       in_clk,
    input logic                       in_reset_n,
    input logic                       out_clk,
    input logic                       out_reset_n,
    input logic                       in_ready,
    input logic [`DCF_DATA_WIDTH-1:0] out_data,
    input logic                       out_startofpacket,
    input logic                       out_endofpacket,
    input logic                       out_valid,
    input logic                       out_ready,
    input dc_fifo_pkg::level_t        out_level
);

    int fails = 0;

    // A stalled beat stays put until it is taken
    hold_stable: assert property (@(posedge out_clk) disable iff (!out_reset_n)
        out_valid && !out_ready |=>
            out_valid && $stable({out_startofpacket, out_endofpacket, out_data}))
        else begin
            $error("output beat changed while stalled");
            fails++;
        end

    ready_after_reset: assert property (@(posedge in_clk) $rose(in_reset_n) |-> in_ready)
        else begin
            $error("in_ready low when reset was released");
            fails++;
        end

    idle_in_reset: assert property (@(posedge out_clk) !out_reset_n |-> !out_valid)
        else begin
            $error("out_valid high during reset");
            fails++;
        end

    // Memory plus the output stage
    level_bound: assert property (@(posedge out_clk) disable iff (!out_reset_n)
        out_level <= `DCF_DEPTH + 1)
        else begin
            $error("output level above capacity");
            fails++;
        end

endmodule

bind dc_fifo_top dc_fifo_chk i_chk (
    .in_clk            (in_clk),
    .in_reset_n        (in_reset_n),
    .out_clk           (out_clk),
    .out_reset_n       (out_reset_n),
    .in_ready          (in_ready),
    .out_data          (out_data),
    .out_startofpacket (out_startofpacket),
    .out_endofpacket   (out_endofpacket),
    .out_valid         (out_valid),
    .out_ready         (out_ready),
    .out_level         (out_level)
);

// File: sim/dc_fifo_tb.sv
/*
 * Dual-clock FIFO testbench
 * Random stream traffic on two clocks, CSR accesses, filling to
 * capacity under back-pressure and threshold status checks
 */
`timescale 1ns/1ps
`include "dc_fifo_consts.svh"

module dc_fifo_tb;

    localparam int STREAM_BEATS = 500;
    localparam int WAIT_LIMIT   = 20000;
    localparam int QUIET_CYCLES = 20;

    logic                       in_clk;
    logic                       in_reset_n;
    logic                       out_clk;
    logic                       out_reset_n;
    logic [`DCF_DATA_WIDTH-1:0] in_data;
    logic                       in_startofpacket;
    logic                       in_endofpacket;
    logic                       in_valid;
    logic                       in_ready;
    logic [`DCF_DATA_WIDTH-1:0] out_data;
    logic                       out_startofpacket;
    logic                       out_endofpacket;
    logic                       out_valid;
    logic                       out_ready;
    logic                       in_csr_address;
    logic                       in_csr_read;
    logic                       in_csr_write;
    logic [`DCF_CSR_WIDTH-1:0]  in_csr_writedata;
    logic [`DCF_CSR_WIDTH-1:0]  in_csr_readdata;
    logic                       out_csr_address;
    logic                       out_csr_read;
    logic                       out_csr_write;
    logic [`DCF_CSR_WIDTH-1:0]  out_csr_writedata;
    logic [`DCF_CSR_WIDTH-1:0]  out_csr_readdata;
    logic                       almost_full_valid;
    logic                       almost_full_data;
    logic                       almost_empty_valid;
    logic                       almost_empty_data;
    int                         timeouts = 0;

    tb_clk_gen #(.PERIOD_NS(4.0)) i_in_clk_gen (.clk(in_clk), .reset_n(in_reset_n));
    tb_clk_gen #(.PERIOD_NS(6.0)) i_out_clk_gen (.clk(out_clk), .reset_n(out_reset_n));

    dc_fifo_top i_dut (.*);

    dc_fifo_monitor i_mon (.*);

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timed out while waiting for %s", what);
    endtask

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic drive_beat(input bit valid);
        in_valid         <= valid;
        in_data          <= $urandom;
        in_startofpacket <= $urandom_range(0, 1);
        in_endofpacket   <= $urandom_range(0, 1);
    endtask

    // A new beat is offered only once the previous one was taken
    task automatic send_beats(input int n, input bit gaps);
        int sent;
        int guard;
        sent = 0;
        guard = 0;
        while (sent < n && guard < WAIT_LIMIT) begin
            @(posedge in_clk);
            guard++;
            if (in_valid && in_ready) begin
                sent++;
            end
            if (!in_valid || in_ready) begin
                drive_beat(sent < n && (!gaps || $urandom_range(0, 3) != 0));
            end
        end
        if (sent < n) begin
            note_timeout("input beats to be accepted");
        end
    endtask

    task automatic csr_access(input bit out_side, input bit write, input bit addr,
                              input logic [`DCF_CSR_WIDTH-1:0] wdata,
                              output logic [`DCF_CSR_WIDTH-1:0] rdata);
        if (!out_side) begin
            @(posedge in_clk);
            in_csr_address   <= addr;
            in_csr_write     <= write;
            in_csr_read      <= !write;
            in_csr_writedata <= wdata;
            @(posedge in_clk);
            in_csr_write <= 1'b0;
            in_csr_read  <= 1'b0;
            @(posedge in_clk);
            rdata = in_csr_readdata;
        end else begin
            @(posedge out_clk);
            out_csr_address   <= addr;
            out_csr_write     <= write;
            out_csr_read      <= !write;
            out_csr_writedata <= wdata;
            @(posedge out_clk);
            out_csr_write <= 1'b0;
            out_csr_read  <= 1'b0;
            @(posedge out_clk);
            rdata = out_csr_readdata;
        end
    endtask

    task automatic run_stream();
        int target;
        int guard;
        target = i_mon.popped + STREAM_BEATS;
        guard = 0;
        fork
            send_beats(STREAM_BEATS, 1'b1);
            begin
                while (i_mon.popped < target && guard < WAIT_LIMIT) begin
                    @(posedge out_clk);
                    guard++;
                    out_ready <= $urandom_range(0, 1);
                end
                out_ready <= 1'b0;
                if (i_mon.popped < target) begin
                    note_timeout("output beats of the stream test");
                end
            end
        join
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        while ((i_mon.pending() != 0 || out_valid) && guard < WAIT_LIMIT) begin
            @(posedge out_clk);
            guard++;
            out_ready <= 1'b1;
        end
        @(posedge out_clk);
        out_ready <= 1'b0;
        if (guard >= WAIT_LIMIT) begin
            note_timeout("the FIFO to drain");
        end
    endtask

    // Stops after in_ready has been low for a run of quiet cycles
    task automatic fill_to_capacity();
        int low_run;
        int guard;
        low_run = 0;
        guard = 0;
        while (low_run < QUIET_CYCLES && guard < WAIT_LIMIT) begin
            @(posedge in_clk);
            guard++;
            low_run = in_ready ? 0 : low_run + 1;
            if (!in_valid || in_ready) begin
                drive_beat(1'b1);
            end
        end
        in_valid <= 1'b0;
        if (low_run < QUIET_CYCLES) begin
            note_timeout("in_ready to stay low");
        end
    endtask

    task automatic check_status(input string name);
        logic [`DCF_CSR_WIDTH-1:0] unused;
        logic [`DCF_CSR_WIDTH-1:0] in_lvl;
        logic [`DCF_CSR_WIDTH-1:0] in_th;
        logic [`DCF_CSR_WIDTH-1:0] out_lvl;
        logic [`DCF_CSR_WIDTH-1:0] out_th;
        csr_access(1'b0, 1'b1, `DCF_CSR_ADDR_THRESH, $urandom_range(0, `DCF_DEPTH + 1), unused);
        csr_access(1'b1, 1'b1, `DCF_CSR_ADDR_THRESH, $urandom_range(0, `DCF_DEPTH + 1), unused);
        repeat (QUIET_CYCLES) @(posedge in_clk);
        csr_access(1'b0, 1'b0, `DCF_CSR_ADDR_LEVEL, '0, in_lvl);
        csr_access(1'b0, 1'b0, `DCF_CSR_ADDR_THRESH, '0, in_th);
        csr_access(1'b1, 1'b0, `DCF_CSR_ADDR_LEVEL, '0, out_lvl);
        csr_access(1'b1, 1'b0, `DCF_CSR_ADDR_THRESH, '0, out_th);
        @(posedge in_clk);
        i_mon.compare({name, " almost_full"}, in_lvl >= in_th, almost_full_data);
        @(posedge out_clk);
        i_mon.compare({name, " almost_empty"}, out_lvl <= out_th, almost_empty_data);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin : main
        logic [`DCF_CSR_WIDTH-1:0] wdata;
        logic [`DCF_CSR_WIDTH-1:0] rdata;
        int                        guard;
        int                        errors;

        void'($urandom(32'h22d1_8f2e));
        in_data           <= '0;
        in_startofpacket  <= 1'b0;
        in_endofpacket    <= 1'b0;
        in_valid          <= 1'b0;
        out_ready         <= 1'b0;
        in_csr_address    <= 1'b0;
        in_csr_read       <= 1'b0;
        in_csr_write      <= 1'b0;
        in_csr_writedata  <= '0;
        out_csr_address   <= 1'b0;
        out_csr_read      <= 1'b0;
        out_csr_write     <= 1'b0;
        out_csr_writedata <= '0;

        // Both resets still held here
        @(posedge in_clk);
        i_mon.compare("reset in_ready", 1, in_ready);
        i_mon.compare("reset out_valid", 0, out_valid);
        i_mon.compare("reset almost_full_valid", 0, almost_full_valid);
        i_mon.compare("reset almost_empty_valid", 0, almost_empty_valid);

        guard = 0;
        while (!(in_reset_n && out_reset_n) && guard < 100) begin
            @(posedge in_clk);
            guard++;
        end
        if (!(in_reset_n && out_reset_n)) begin
            note_timeout("reset release");
        end

        for (int side = 0; side < 2; side++) begin
            csr_access(side, 1'b0, `DCF_CSR_ADDR_LEVEL, '0, rdata);
            i_mon.compare("reset level read", 0, rdata);
            csr_access(side, 1'b0, `DCF_CSR_ADDR_THRESH, '0, rdata);
            i_mon.compare("reset threshold read", 0, rdata);
        end
        i_mon.compare("almost_full_valid after reset", 1, almost_full_valid);
        i_mon.compare("almost_empty_valid after reset", 1, almost_empty_valid);

        // Only the low field of the threshold is kept
        for (int i = 0; i < 6; i++) begin
            wdata = $urandom;
            csr_access(i % 2, 1'b1, `DCF_CSR_ADDR_THRESH, wdata, rdata);
            csr_access(i % 2, 1'b0, `DCF_CSR_ADDR_THRESH, '0, rdata);
            i_mon.compare("threshold readback",
                          wdata & ((32'h1 << `DCF_CSR_LEVEL_BITS) - 1), rdata);
        end
        check_status("status empty");

        run_stream();
        drain();

        send_beats(`DCF_DEPTH / 2, 1'b0);
        check_status("status half");

        fill_to_capacity();
        i_mon.compare("capacity beats", `DCF_DEPTH + 1, i_mon.pending());
        csr_access(1'b1, 1'b0, `DCF_CSR_ADDR_LEVEL, '0, rdata);
        i_mon.compare("capacity output level", `DCF_DEPTH + 1, rdata);
        csr_access(1'b0, 1'b0, `DCF_CSR_ADDR_LEVEL, '0, rdata);
        i_mon.compare("capacity input level", `DCF_DEPTH, rdata);
        check_status("status full");
        drain();

        errors = i_mon.stream_errs + i_mon.value_errs + timeouts + i_dut.i_chk.fails;
        $display("errors: stream %0d, values %0d, timeouts %0d, assertions %0d",
                 i_mon.stream_errs, i_mon.value_errs, timeouts, i_dut.i_chk.fails);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+logic
logic/dc_fifo_pkg.sv
logic/dc_fifo_mem.sv
logic/dc_fifo_ptr_sync.sv
logic/dc_fifo_wr_ctrl.sv
logic/dc_fifo_rd_ctrl.sv
logic/dc_fifo_level_csr.sv
logic/dc_fifo_top.sv
sim/tb_clk_gen.sv
sim/dc_fifo_monitor.sv
sim/dc_fifo_chk.sv
sim/dc_fifo_tb.sv

// File: Bender.yml
package:
  name: dc_fifo

export_include_dirs:
  - logic

sources:
  - logic/dc_fifo_pkg.sv
  - logic/dc_fifo_mem.sv
  - logic/dc_fifo_ptr_sync.sv
  - logic/dc_fifo_wr_ctrl.sv
  - logic/dc_fifo_rd_ctrl.sv
  - logic/dc_fifo_level_csr.sv
  - logic/dc_fifo_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/dc_fifo_monitor.sv
      - sim/dc_fifo_chk.sv
      - sim/dc_fifo_tb.sv
